// ==== hdl/isaPkg.sv ====
`default_nettype none

package isaPkg;

    //////////////////////////////////////////////////
    // datapath sizes.
    //////////////////////////////////////////////////

    localparam int dataWidth = 32;
    localparam int regCount = 16;

    //////////////////////////////////////////////////
    // alu operations, coded as in the opcode field.
    //////////////////////////////////////////////////

    typedef enum logic [4:0] {
        opAdd = 5'b00011,
        opSub = 5'b00100,
        opShr = 5'b00101,
        opShl = 5'b00111,
        opRor = 5'b01000,
        opRol = 5'b01001,
        opAnd = 5'b01010,
        opOr  = 5'b01011,
        opMul = 5'b01111,
        opNeg = 5'b10001,
        opNot = 5'b10010
    } aluOp_t;

endpackage

`default_nettype wire

// ==== hdl/busPkg.sv ====
`default_nettype none

package busPkg;

    // sources that can drive the shared bus.
    typedef enum logic [3:0] {
        srcNone  = 4'd0,
        srcGpr   = 4'd1,
        srcPc    = 4'd2,
        srcMdr   = 4'd3,
        srcHi    = 4'd4,
        srcLo    = 4'd5,
        srcZHigh = 4'd6,
        srcZLow  = 4'd7
    } busSrc_t;

    // srcNone included.
    localparam int srcCount = 8;

endpackage

`default_nettype wire

// ==== hdl/regPortIf.sv ====
`default_nettype none

interface regPortIf #(
    parameter int DataWidth = 32,
    parameter int RegCount = 16
);

    // one-hot strobes from the top level.
    logic [RegCount-1:0] inEn;
    logic [RegCount-1:0] outEn;
    // bus value and the selected register.
    logic [DataWidth-1:0] busValue;
    logic [DataWidth-1:0] gprValue;

    modport regs (
        input  inEn,
        input  outEn,
        input  busValue,
        output gprValue
    );

    modport mux (
        input  outEn,
        input  gprValue,
        output busValue
    );

endinterface

`default_nettype wire

// ==== hdl/regFile.sv ====
`default_nettype none

module regFile #(
    parameter int DataWidth = 32,
    parameter int RegCount = 16
) (
    input  wire logic Clock,
    input  wire logic rst,
    regPortIf.regs    regPort
);

    logic [DataWidth-1:0] slotValue [RegCount];

    //////////////////////////////////////////////////
    // register slots.
    //////////////////////////////////////////////////

    for (genvar i = 0; i < RegCount; i++) begin : gSlot
        logic [DataWidth-1:0] slotQ;

        always_ff @(posedge Clock) begin
            if (rst) begin
                slotQ <= '0;
            end else if (regPort.inEn[i]) begin
                slotQ <= regPort.busValue;
            end
        end

        assign slotValue[i] = slotQ;
    end

    // selected slots are OR-ed onto the read port.
    always_comb begin
        regPort.gprValue = '0;
        for (int i = 0; i < RegCount; i++) begin
            if (regPort.outEn[i]) begin
                regPort.gprValue = regPort.gprValue | slotValue[i];
            end
        end
    end

    // at most one register written and one read per cycle.
    strobeOneHot: assert property (
        @(posedge Clock) disable iff (rst)
        $onehot0(regPort.inEn) && $onehot0(regPort.outEn)
    ) else $error("register strobes not one-hot");

endmodule

`default_nettype wire

// ==== hdl/busMux.sv ====
`default_nettype none

module busMux #(
    parameter int DataWidth = 32
) (
    input  wire logic                   Clock,
    input  wire logic                   pcOut,
    input  wire logic                   mdrOut,
    input  wire logic                   hiOut,
    input  wire logic                   loOut,
    input  wire logic                   zHighOut,
    input  wire logic                   zLowOut,
    input  wire logic [DataWidth-1:0]   pcValue,
    input  wire logic [DataWidth-1:0]   mdrValue,
    input  wire logic [DataWidth-1:0]   hiValue,
    input  wire logic [DataWidth-1:0]   loValue,
    input  wire logic [2*DataWidth-1:0] zValue,
    regPortIf.mux                       regPort
);

    logic gprSel;
    logic [busPkg::srcCount-2:0] strobes;
    busPkg::busSrc_t src;

    assign gprSel = |regPort.outEn;
    assign strobes = {gprSel, pcOut, mdrOut, hiOut, loOut, zHighOut, zLowOut};

    // strobe encoder.
    always_comb begin
        src = busPkg::srcNone;
        if (gprSel) begin
            src = busPkg::srcGpr;
        end else if (pcOut) begin
            src = busPkg::srcPc;
        end else if (mdrOut) begin
            src = busPkg::srcMdr;
        end else if (hiOut) begin
            src = busPkg::srcHi;
        end else if (loOut) begin
            src = busPkg::srcLo;
        end else if (zHighOut) begin
            src = busPkg::srcZHigh;
        end else if (zLowOut) begin
            src = busPkg::srcZLow;
        end
    end

    // idle bus reads zero.
    always_comb begin
        case (src)
            busPkg::srcGpr:   regPort.busValue = regPort.gprValue;
            busPkg::srcPc:    regPort.busValue = pcValue;
            busPkg::srcMdr:   regPort.busValue = mdrValue;
            busPkg::srcHi:    regPort.busValue = hiValue;
            busPkg::srcLo:    regPort.busValue = loValue;
            busPkg::srcZHigh: regPort.busValue = zValue[2*DataWidth-1:DataWidth];
            busPkg::srcZLow:  regPort.busValue = zValue[DataWidth-1:0];
            default:          regPort.busValue = '0;
        endcase
    end

    singleDriver: assert property (@(posedge Clock) $onehot0(strobes))
        else $error("more than one bus driver");

endmodule

`default_nettype wire

// ==== hdl/aluUnit.sv ====
`default_nettype none

module aluUnit #(
    parameter int DataWidth = 32
) (
    input  wire logic                   Clock,
    input  wire logic                   rst,
    input  wire logic [DataWidth-1:0]   bus,
    input  wire logic                   yIn,
    input  wire logic                   zIn,
    input  wire isaPkg::aluOp_t         aluOp,
    output      logic [2*DataWidth-1:0] zValue
);

    localparam int ShiftBits = $clog2(DataWidth);

    logic [DataWidth-1:0] yQ;
    logic [ShiftBits-1:0] shamt;
    logic [2*DataWidth-1:0] rolWide;
    logic [2*DataWidth-1:0] rorWide;
    logic signed [2*DataWidth-1:0] yWide;
    logic signed [2*DataWidth-1:0] busWide;
    logic signed [2*DataWidth-1:0] product;
    logic [2*DataWidth-1:0] result;

    //////////////////////////////////////////////////
    // Y latch.
    //////////////////////////////////////////////////

    always_ff @(posedge Clock) begin
        if (rst) begin
            yQ <= '0;
        end else if (yIn) begin
            yQ <= bus;
        end
    end

    //////////////////////////////////////////////////
    // operations on Y and the bus.
    //////////////////////////////////////////////////

    assign shamt = bus[ShiftBits-1:0];
    // doubled word, so the rotated value sits in one half.
    assign rolWide = {yQ, yQ} << shamt;
    assign rorWide = {yQ, yQ} >> shamt;

    assign yWide = {{DataWidth{yQ[DataWidth-1]}}, yQ};
    assign busWide = {{DataWidth{bus[DataWidth-1]}}, bus};
    assign product = yWide * busWide;

    // high word stays zero except for mul.
    always_comb begin
        result = '0;
        case (aluOp)
            isaPkg::opAdd: result[DataWidth-1:0] = yQ + bus;
            isaPkg::opSub: result[DataWidth-1:0] = yQ - bus;
            isaPkg::opAnd: result[DataWidth-1:0] = yQ & bus;
            isaPkg::opOr:  result[DataWidth-1:0] = yQ | bus;
            isaPkg::opShl: result[DataWidth-1:0] = yQ << shamt;
            isaPkg::opShr: result[DataWidth-1:0] = yQ >> shamt;
            isaPkg::opRol: result[DataWidth-1:0] = rolWide[2*DataWidth-1:DataWidth];
            isaPkg::opRor: result[DataWidth-1:0] = rorWide[DataWidth-1:0];
            // unary ops take the bus operand.
            isaPkg::opNeg: result[DataWidth-1:0] = -bus;
            isaPkg::opNot: result[DataWidth-1:0] = ~bus;
            isaPkg::opMul: result = product;
            default:       result = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            zValue <= '0;
        end else if (zIn) begin
            zValue <= result;
        end
    end

    legalOp: assert property (
        @(posedge Clock) disable iff (rst)
        zIn |-> aluOp inside {isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd,
                              isaPkg::opOr, isaPkg::opShl, isaPkg::opShr,
                              isaPkg::opRol, isaPkg::opRor, isaPkg::opNeg,
                              isaPkg::opNot, isaPkg::opMul}
    ) else $error("Z loaded with an illegal ALU op");

endmodule

`default_nettype wire

// ==== hdl/specialRegs.sv ====
`default_nettype none

module specialRegs #(
    parameter int DataWidth = 32
) (
    input  wire logic                 Clock,
    input  wire logic                 rst,
    input  wire logic [DataWidth-1:0] bus,
    input  wire logic [DataWidth-1:0] mdataIn,
    input  wire logic                 read,
    input  wire logic                 incPc,
    input  wire logic                 pcIn,
    input  wire logic                 irIn,
    input  wire logic                 marIn,
    input  wire logic                 mdrIn,
    input  wire logic                 hiIn,
    input  wire logic                 loIn,
    output      logic [DataWidth-1:0] pcValue,
    output      logic [DataWidth-1:0] mdrValue,
    output      logic [DataWidth-1:0] hiValue,
    output      logic [DataWidth-1:0] loValue,
    output      logic [DataWidth-1:0] address,
    output      logic [DataWidth-1:0] instr
);

    localparam logic [DataWidth-1:0] PcStep = DataWidth'(4);

    //////////////////////////////////////////////////
    // PC and IR.
    //////////////////////////////////////////////////

    always_ff @(posedge Clock) begin
        if (rst) begin
            pcValue <= '0;
            instr <= '0;
        end else begin
            if (pcIn) begin
                pcValue <= incPc ? pcValue + PcStep : bus;
            end
            if (irIn) begin
                instr <= bus;
            end
        end
    end

    //////////////////////////////////////////////////
    // memory interface and HI/LO.
    //////////////////////////////////////////////////

    always_ff @(posedge Clock) begin
        if (rst) begin
            address <= '0;
            mdrValue <= '0;
            hiValue <= '0;
            loValue <= '0;
        end else begin
            if (marIn) begin
                address <= bus;
            end
            // read selects the memory word over the bus.
            if (mdrIn) begin
                mdrValue <= read ? mdataIn : bus;
            end
            if (hiIn) begin
                hiValue <= bus;
            end
            if (loIn) begin
                loValue <= bus;
            end
        end
    end

    incWithLoad: assert property (@(posedge Clock) disable iff (rst) incPc |-> pcIn)
        else $error("incPc without pcIn");

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
`default_nettype none

module datapath #(
    parameter int DataWidth = isaPkg::dataWidth,
    parameter int RegCount = isaPkg::regCount
) (
    input  wire logic                 Clock,
    input  wire logic                 rst,
    input  wire logic [DataWidth-1:0] mdataIn,
    input  wire logic                 read,
    input  wire logic                 incPc,
    input  wire logic [RegCount-1:0]  regIn,
    input  wire logic [RegCount-1:0]  regOut,
    input  wire logic                 pcIn,
    input  wire logic                 pcOut,
    input  wire logic                 irIn,
    input  wire logic                 marIn,
    input  wire logic                 mdrIn,
    input  wire logic                 mdrOut,
    input  wire logic                 yIn,
    input  wire logic                 zIn,
    input  wire logic                 zHighOut,
    input  wire logic                 zLowOut,
    input  wire logic                 hiIn,
    input  wire logic                 hiOut,
    input  wire logic                 loIn,
    input  wire logic                 loOut,
    input  wire isaPkg::aluOp_t       aluOp,
    output      logic [DataWidth-1:0] bus,
    output      logic [DataWidth-1:0] address,
    output      logic [DataWidth-1:0] instr
);

    logic [DataWidth-1:0] pcValue;
    logic [DataWidth-1:0] mdrValue;
    logic [DataWidth-1:0] hiValue;
    logic [DataWidth-1:0] loValue;
    logic [2*DataWidth-1:0] zValue;

    regPortIf #(.DataWidth(DataWidth), .RegCount(RegCount)) regPort ();

    assign regPort.inEn = regIn;
    assign regPort.outEn = regOut;
    assign bus = regPort.busValue;

    //////////////////////////////////////////////////
    // bus sources and sinks.
    //////////////////////////////////////////////////

    regFile #(
        .DataWidth(DataWidth),
        .RegCount(RegCount)
    ) gprFile (
        .Clock   (Clock),
        .rst     (rst),
        .regPort (regPort.regs)
    );

    busMux #(
        .DataWidth(DataWidth)
    ) busDriver (
        .Clock    (Clock),
        .pcOut    (pcOut),
        .mdrOut   (mdrOut),
        .hiOut    (hiOut),
        .loOut    (loOut),
        .zHighOut (zHighOut),
        .zLowOut  (zLowOut),
        .pcValue  (pcValue),
        .mdrValue (mdrValue),
        .hiValue  (hiValue),
        .loValue  (loValue),
        .zValue   (zValue),
        .regPort  (regPort.mux)
    );

    aluUnit #(
        .DataWidth(DataWidth)
    ) alu (
        .Clock  (Clock),
        .rst    (rst),
        .bus    (regPort.busValue),
        .yIn    (yIn),
        .zIn    (zIn),
        .aluOp  (aluOp),
        .zValue (zValue)
    );

    specialRegs #(
        .DataWidth(DataWidth)
    ) special (
        .Clock    (Clock),
        .rst      (rst),
        .bus      (regPort.busValue),
        .mdataIn  (mdataIn),
        .read     (read),
        .incPc    (incPc),
        .pcIn     (pcIn),
        .irIn     (irIn),
        .marIn    (marIn),
        .mdrIn    (mdrIn),
        .hiIn     (hiIn),
        .loIn     (loIn),
        .pcValue  (pcValue),
        .mdrValue (mdrValue),
        .hiValue  (hiValue),
        .loValue  (loValue),
        .address  (address),
        .instr    (instr)
    );

endmodule

`default_nettype wire

// ==== sim/datapathTb.sv ====
`default_nettype none

module datapathTb;

    localparam int CycleLimit = 4000;

    logic Clock;
    logic rst;
    logic [31:0] mdataIn;
    logic read;
    logic incPc;
    logic [15:0] regIn;
    logic [15:0] regOut;
    logic pcIn;
    logic pcOut;
    logic irIn;
    logic marIn;
    logic mdrIn;
    logic mdrOut;
    logic yIn;
    logic zIn;
    logic zHighOut;
    logic zLowOut;
    logic hiIn;
    logic hiOut;
    logic loIn;
    logic loOut;
    isaPkg::aluOp_t aluOp;
    logic [31:0] bus;
    logic [31:0] address;
    logic [31:0] instr;

    // model state.
    logic [31:0] gprModel [16];
    logic [31:0] pcModel;
    logic [63:0] zModel;
    logic [31:0] busModel;
    logic [31:0] addressModel;
    logic [31:0] instrModel;
    logic busExpected;
    logic outputsExpected;
    int errorCount;
    int checkCount;
    int seed;

    datapath dut_i (
        .Clock(Clock), .rst(rst), .mdataIn(mdataIn), .read(read), .incPc(incPc),
        .regIn(regIn), .regOut(regOut), .pcIn(pcIn), .pcOut(pcOut), .irIn(irIn),
        .marIn(marIn), .mdrIn(mdrIn), .mdrOut(mdrOut), .yIn(yIn), .zIn(zIn),
        .zHighOut(zHighOut), .zLowOut(zLowOut), .hiIn(hiIn), .hiOut(hiOut),
        .loIn(loIn), .loOut(loOut), .aluOp(aluOp), .bus(bus), .address(address),
        .instr(instr)
    );

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    initial begin : watchdog
        for (int c = 0; c < CycleLimit; c++) begin
            @(posedge Clock);
        end
        $display("timeout: run did not finish within %0d cycles", CycleLimit);
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // checks.
    //////////////////////////////////////////////////

    busCheck: assert property (@(posedge Clock) disable iff (rst)
        busExpected |-> bus == busModel)
        else begin
            errorCount++;
            $display("error %0t: bus reads %h, expected %h", $time,
                     $sampled(bus), $sampled(busModel));
        end

    outputCheck: assert property (@(posedge Clock) disable iff (rst)
        outputsExpected |-> (address == addressModel && instr == instrModel))
        else begin
            errorCount++;
            $display("error %0t: address %h instr %h, expected %h %h", $time,
                     $sampled(address), $sampled(instr),
                     $sampled(addressModel), $sampled(instrModel));
        end

    // expected ALU result, low word only except for mul.
    function automatic logic [63:0] aluModel(isaPkg::aluOp_t op, logic [31:0] y,
                                             logic [31:0] b);
        int n;
        logic [31:0] low;
        longint ys;
        longint bs;
        n = {27'd0, b[4:0]};
        low = '0;
        ys = longint'($signed(y));
        bs = longint'($signed(b));
        case (op)
            isaPkg::opAdd: low = y + b;
            isaPkg::opSub: low = y - b;
            isaPkg::opAnd: low = y & b;
            isaPkg::opOr:  low = y | b;
            isaPkg::opShl: low = y << n;
            isaPkg::opShr: low = y >> n;
            isaPkg::opNeg: low = -b;
            isaPkg::opNot: low = ~b;
            isaPkg::opRol: begin
                low = y;
                for (int i = 0; i < n; i++) begin
                    low = {low[30:0], low[31]};
                end
            end
            isaPkg::opRor: begin
                low = y;
                for (int i = 0; i < n; i++) begin
                    low = {low[0], low[31:1]};
                end
            end
            isaPkg::opMul: return ys * bs;
            default:       low = '0;
        endcase
        return {32'd0, low};
    endfunction

    //////////////////////////////////////////////////
    // control sequences.
    //////////////////////////////////////////////////

    task automatic clearControls();
        read = 1'b0;
        incPc = 1'b0;
        regIn = '0;
        regOut = '0;
        {pcIn, pcOut, irIn, marIn, mdrIn, mdrOut} = '0;
        {yIn, zIn, zHighOut, zLowOut, hiIn, hiOut, loIn, loOut} = '0;
        aluOp = isaPkg::opAdd;
        busExpected = 1'b0;
        outputsExpected = 1'b0;
    endtask

    task automatic expectOnBus(input logic [31:0] value);
        busExpected = 1'b1;
        busModel = value;
        checkCount++;
    endtask

    // sel is {pcOut, mdrOut, hiOut, loOut, zHighOut, zLowOut}.
    task automatic sourceToBus(input logic [5:0] sel, input logic [31:0] value);
        @(negedge Clock);
        clearControls();
        {pcOut, mdrOut, hiOut, loOut, zHighOut, zLowOut} = sel;
        expectOnBus(value);
    endtask

    task automatic registerToBus(input int r);
        @(negedge Clock);
        clearControls();
        regOut[r] = 1'b1;
        expectOnBus(gprModel[r]);
    endtask

    task automatic memoryToRegister(input int r, input logic [31:0] word);
        @(negedge Clock);
        clearControls();
        mdataIn = word;
        read = 1'b1;
        mdrIn = 1'b1;
        @(negedge Clock);
        clearControls();
        mdrOut = 1'b1;
        regIn[r] = 1'b1;
        expectOnBus(word);
        gprModel[r] = word;
    endtask

    task automatic busToMdr(input int r);
        @(negedge Clock);
        clearControls();
        regOut[r] = 1'b1;
        mdrIn = 1'b1;
        expectOnBus(gprModel[r]);
        sourceToBus(6'b010000, gprModel[r]);
    endtask

    task automatic aluFromRegisters(input isaPkg::aluOp_t op, input int ra, input int rb);
        @(negedge Clock);
        clearControls();
        regOut[ra] = 1'b1;
        yIn = 1'b1;
        expectOnBus(gprModel[ra]);
        @(negedge Clock);
        clearControls();
        regOut[rb] = 1'b1;
        zIn = 1'b1;
        aluOp = op;
        expectOnBus(gprModel[rb]);
        zModel = aluModel(op, gprModel[ra], gprModel[rb]);
    endtask

    // a negative r leaves the word on the bus only.
    task automatic zToRegister(input logic high, input int r);
        logic [31:0] value;
        value = high ? zModel[63:32] : zModel[31:0];
        @(negedge Clock);
        clearControls();
        zHighOut = high;
        zLowOut = ~high;
        if (r >= 0) begin
            regIn[r] = 1'b1;
            gprModel[r] = value;
        end
        expectOnBus(value);
    endtask

    task automatic productToHiLo();
        @(negedge Clock);
        clearControls();
        zHighOut = 1'b1;
        hiIn = 1'b1;
        expectOnBus(zModel[63:32]);
        @(negedge Clock);
        clearControls();
        zLowOut = 1'b1;
        loIn = 1'b1;
        expectOnBus(zModel[31:0]);
        sourceToBus(6'b001000, zModel[63:32]);
        sourceToBus(6'b000100, zModel[31:0]);
    endtask

    task automatic pcIncrement(input int r);
        @(negedge Clock);
        clearControls();
        regOut[r] = 1'b1;
        pcIn = 1'b1;
        expectOnBus(gprModel[r]);
        pcModel = gprModel[r];
        @(negedge Clock);
        clearControls();
        pcIn = 1'b1;
        incPc = 1'b1;
        expectOnBus('0);
        pcModel = pcModel + 32'd4;
        sourceToBus(6'b100000, pcModel);
    endtask

    task automatic marAndIr(input int ra, input int rb);
        @(negedge Clock);
        clearControls();
        regOut[ra] = 1'b1;
        marIn = 1'b1;
        expectOnBus(gprModel[ra]);
        addressModel = gprModel[ra];
        @(negedge Clock);
        clearControls();
        regOut[rb] = 1'b1;
        irIn = 1'b1;
        expectOnBus(gprModel[rb]);
        instrModel = gprModel[rb];
        @(negedge Clock);
        clearControls();
        outputsExpected = 1'b1;
        checkCount++;
    endtask

    task automatic resetReadback();
        for (int r = 0; r < 16; r++) begin
            registerToBus(r);
        end
        for (int s = 0; s < 6; s++) begin
            sourceToBus(6'b000001 << s, '0);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus.
    //////////////////////////////////////////////////

    initial begin : stimulus
        isaPkg::aluOp_t opList [10];
        logic [31:0] a;
        logic [31:0] b;
        seed = 40;
        errorCount = 0;
        checkCount = 0;
        rst = 1'b1;
        mdataIn = '0;
        clearControls();
        for (int r = 0; r < 16; r++) begin
            gprModel[r] = '0;
        end
        zModel = '0;
        opList = '{isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr,
                   isaPkg::opShl, isaPkg::opShr, isaPkg::opRol, isaPkg::opRor,
                   isaPkg::opNeg, isaPkg::opNot};
        for (int i = 0; i < 2; i++) begin
            @(negedge Clock);
        end
        rst = 1'b0;

        resetReadback();

        a = $random(seed);
        memoryToRegister(1, a);
        registerToBus(1);
        b = $random(seed);
        memoryToRegister(2, b);
        busToMdr(1);

        for (int k = 0; k < 10; k++) begin
            for (int round = 0; round < 2; round++) begin
                a = $random(seed);
                b = $random(seed);
                memoryToRegister(5, a);
                memoryToRegister(6, b);
                aluFromRegisters(opList[k], 5, 6);
                zToRegister(1'b0, 7);
                zToRegister(1'b1, -1);
                registerToBus(7);
            end
        end

        // products with mixed signs.
        for (int round = 0; round < 3; round++) begin
            a = $random(seed);
            b = $random(seed);
            a[31] = round[0];
            b[31] = round[1];
            memoryToRegister(8, a);
            memoryToRegister(9, b);
            aluFromRegisters(isaPkg::opMul, 8, 9);
            productToHiLo();
        end

        memoryToRegister(10, $random(seed));
        pcIncrement(10);
        memoryToRegister(11, $random(seed));
        memoryToRegister(12, $random(seed));
        marAndIr(11, 12);

        @(negedge Clock);
        clearControls();
        @(negedge Clock);
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/isaPkg.sv
hdl/busPkg.sv
hdl/regPortIf.sv
hdl/regFile.sv
hdl/busMux.sv
hdl/aluUnit.sv
hdl/specialRegs.sv
hdl/datapath.sv
sim/datapathTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module datapathTb -f files.f -o simv \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0
